// File: Makefile
# Verilator build and run of the memory subsystem testbench
TOP       ?= cps_mem_tb
FILELIST  ?= cps_mem_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit status is not used
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cps_mem_top.f
hdl/cps_mem_pkg.sv
hdl/cps_rom_loader.sv
hdl/cps_slot_req.sv
hdl/cps_slot_arbiter.sv
hdl/cps_mem_top.sv
dv/cps_sdram_model.sv
dv/cps_mem_tb.sv

// File: dv/cps_mem_tb.sv
// Fixed-seed random test of download, slot reads, RAM writes and contention; each wait gives up after 200 cycles
`timescale 1ns/10ps

module cps_mem_tb import cps_mem_pkg::*; ();

    logic                VB;
    logic                rst_n;
    logic                downloading;
    logic [22:0]         ioctl_addr;
    logic [ 7:0]         ioctl_data;
    logic                ioctl_wr;
    logic [21:0]         prog_addr;
    logic [ 7:0]         prog_data;
    logic [ 1:0]         prog_mask;
    logic                prog_we;
    logic                rom_cs, ram_cs, gfx_cs, ram_wr;
    logic                rom_ok, ram_ok, gfx_ok;
    logic [19:0]         rom_addr;
    logic [16:0]         ram_addr;
    logic [20:0]         gfx_addr;
    logic [15:0]         rom_data, ram_data, ram_din;
    logic [ 1:0]         ram_mask;
    logic [31:0]         gfx_data;
    logic                sdram_req, sdram_rnw, sdram_ack;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic [15:0]         data_write;
    logic [ 1:0]         sdram_wrmask;
    logic [31:0]         data_read;
    logic [ 2:0]         latency;
    logic [31:0]         rnd_state;
    // Scoreboard copy of the SDRAM words
    logic [15:0]         words [int];

    cps_mem_top uut (.*);

    cps_sdram_model u_sdram (.*);

    initial begin
        VB = 1'b0;
        forever #50 VB = ~VB;
    end

    // Loader owns the memory while downloading
    always @(posedge VB) begin
        if (downloading && sdram_req) begin
            $display("SDRAM request seen during download at %0t", $time);
            stop_run();
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    function automatic logic [15:0] expect_word(input logic [21:0] w);
        if (words.exists(int'(w))) begin
            return words[int'(w)];
        end
        return w[15:0] ^ 16'hA5A5;
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] d,
                                                input logic [1:0] mask_n);
        logic [15:0] r;
        r = old;
        for (int lane = 0; lane < 2; lane++) begin
            if (!mask_n[lane]) begin
                r[lane*8 +: 8] = d[lane*8 +: 8];
            end
        end
        return r;
    endfunction

    // 0 to 2 follow slot_e, 3 is prog_we, 4 is sdram_ack
    function automatic logic probe(input int sel);
        case (sel)
            0: return rom_ok;
            1: return ram_ok;
            2: return gfx_ok;
            3: return prog_we;
            default: return sdram_ack;
        endcase
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word16(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word32(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_prog(input logic [21:0] addr, input logic [7:0] data,
                              input logic [1:0] mask);
        if (prog_addr !== addr || prog_data !== data || prog_mask !== mask) begin
            $display("FAIL %0t: prog write %h %h %b expected %h %h %b", $time,
                     prog_addr, prog_data, prog_mask, addr, data, mask);
            stop_run();
        end
    endtask

    task automatic tick();
        @(negedge VB);
        latency = 3'd1 + 3'(xorshift() % 6);
    endtask

    task automatic check_timeout(input int n, input string what);
        if (n > 200) begin
            $display("Timed out after 200 cycles waiting for %s", what);
            stop_run();
        end
    endtask

    task automatic wait_until(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while (probe(sel) !== level) begin
            tick();
            n++;
            check_timeout(n, what);
        end
    endtask

    task automatic raise_cs(input slot_e s, input logic [20:0] a, input logic wr,
                            input logic [15:0] d, input logic [1:0] m);
        case (s)
            SLOT_ROM: begin
                rom_addr = a[19:0];
                rom_cs   = 1'b1;
            end
            SLOT_RAM: begin
                ram_addr = a[16:0];
                ram_wr   = wr;
                ram_din  = d;
                ram_mask = m;
                ram_cs   = 1'b1;
            end
            default: begin
                gfx_addr = a;
                gfx_cs   = 1'b1;
            end
        endcase
    endtask

    // Called with ok high, checks the data and releases cs
    task automatic finish_slot(input slot_e s, input logic [20:0] a);
        logic [21:0] w;
        case (s)
            SLOT_ROM: begin
                w = ROM_OFFSET + 22'(a);
                check_word16("rom_data", rom_data, expect_word(w));
                rom_cs = 1'b0;
            end
            SLOT_RAM: begin
                w = RAM_OFFSET + 22'(a);
                if (ram_wr) begin
                    words[int'(w)] = merge_bytes(expect_word(w), ram_din, ram_mask);
                end else begin
                    check_word16("ram_data", ram_data, expect_word(w));
                end
                ram_cs = 1'b0;
            end
            default: begin
                w = GFX_OFFSET + 22'(a);
                check_word32("gfx_data", gfx_data, {expect_word(w + 22'd1), expect_word(w)});
                gfx_cs = 1'b0;
            end
        endcase
    endtask

    task automatic access(input slot_e s, input logic [20:0] a, input logic wr,
                          input logic [15:0] d, input logic [1:0] m);
        raise_cs(s, a, wr, d, m);
        wait_until(int'(s), 1'b1, "slot ok");
        finish_slot(s, a);
        wait_until(int'(s), 1'b0, "slot ok release");
    endtask

    // A repeated read is answered by the cache one cycle after cs
    task automatic cached_read(input slot_e s, input logic [20:0] a);
        raise_cs(s, a, 1'b0, 16'd0, 2'b00);
        tick();
        if (probe(int'(s)) !== 1'b1) begin
            $display("Repeated read at %0t was not answered from the cache", $time);
            stop_run();
        end
        finish_slot(s, a);
        wait_until(int'(s), 1'b0, "slot ok release");
    endtask

    task automatic load_byte(input logic [22:0] ba, input logic [7:0] b);
        logic [21:0] w;
        logic [ 1:0] m;
        int          lane;
        w    = 22'(ba / 2);
        // Odd byte addresses land in the low lane
        lane = ba[0] ? 0 : 1;
        m    = ~(2'b01 << lane);
        ioctl_addr = ba;
        ioctl_data = b;
        ioctl_wr   = 1'b1;
        wait_until(3, 1'b1, "prog_we");
        check_prog(w, b, m);
        ioctl_wr = 1'b0;
        words[int'(w)] = merge_bytes(expect_word(w), {b, b}, m);
        wait_until(3, 1'b0, "prog_we release");
        wait_until(4, 1'b0, "sdram_ack release");
    endtask

    initial begin
        logic [20:0] a;
        logic [20:0] ra [3];
        logic [15:0] d;
        logic [ 7:0] b;
        logic [ 2:0] open;
        int          n;
        rnd_state   = 32'h7e62;
        latency     = 3'd1;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        rom_cs      = 1'b0;
        rom_addr    = '0;
        ram_cs      = 1'b0;
        ram_addr    = '0;
        ram_wr      = 1'b0;
        ram_din     = '0;
        ram_mask    = 2'b11;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        repeat (4) tick();
        rst_n = 1'b1;
        tick();
        if (rom_ok !== 1'b0 || ram_ok !== 1'b0 || gfx_ok !== 1'b0 ||
            sdram_req !== 1'b0 || prog_we !== 1'b0) begin
            $display("Handshake outputs are not low after reset");
            stop_run();
        end

        // Bytes into the first 16 words of the CPU ROM and graphics regions
        downloading = 1'b1;
        // ROM read left pending for the whole download
        ra[0] = 21'(xorshift() % 16);
        raise_cs(SLOT_ROM, ra[0], 1'b0, 16'd0, 2'b00);
        for (int i = 0; i < 48; i++) begin
            a = 21'(xorshift() % 32);
            b = 8'(xorshift());
            if (i % 2 == 0) begin
                load_byte(23'(a), b);
            end else begin
                load_byte({GFX_OFFSET, 1'b0} + 23'(a), b);
            end
        end
        downloading = 1'b0;
        wait_until(int'(SLOT_ROM), 1'b1, "slot ok");
        finish_slot(SLOT_ROM, ra[0]);
        wait_until(int'(SLOT_ROM), 1'b0, "slot ok release");

        // Second read of each address comes from the slot cache
        for (int i = 0; i < 24; i++) begin
            a = 21'(xorshift() % 16);
            access(SLOT_ROM, a, 1'b0, 16'd0, 2'b00);
            cached_read(SLOT_ROM, a);
            a = 21'(xorshift() % 16);
            access(SLOT_GFX, a, 1'b0, 16'd0, 2'b00);
            cached_read(SLOT_GFX, a);
        end

        for (int i = 0; i < 16; i++) begin
            a = 21'(xorshift() % 16);
            d = 16'(xorshift());
            access(SLOT_RAM, a, 1'b1, d, 2'(xorshift()));
            access(SLOT_RAM, a, 1'b0, 16'd0, 2'b00);
        end

        // All three slots contend for the SDRAM port
        for (int r = 0; r < 16; r++) begin
            for (int i = 0; i < 3; i++) begin
                ra[i] = 21'(xorshift() % 16);
                raise_cs(slot_e'(i), ra[i], 1'b0, 16'd0, 2'b00);
            end
            open = 3'b111;
            n    = 0;
            while (open != 3'b000) begin
                tick();
                n++;
                check_timeout(n, "all three slots");
                for (int i = 0; i < 3; i++) begin
                    if (open[i] && probe(i)) begin
                        finish_slot(slot_e'(i), ra[i]);
                        open[i] = 1'b0;
                    end
                end
            end
            for (int i = 0; i < 3; i++) begin
                wait_until(i, 1'b0, "slot ok release");
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: dv/cps_sdram_model.sv
// Simulation-only SDRAM; unwritten words read as address XOR A5A5, one access at a time, latency 1 to 7
`timescale 1ns/10ps

module cps_sdram_model (
    input  logic        VB,
    input  logic        rst_n,
    input  logic [ 2:0] latency,
    input  logic        prog_we,
    input  logic [21:0] prog_addr,
    input  logic [ 7:0] prog_data,
    input  logic [ 1:0] prog_mask,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    input  logic        sdram_rnw,
    input  logic [15:0] data_write,
    input  logic [ 1:0] sdram_wrmask,
    output logic        sdram_ack,
    output logic [31:0] data_read
);

    // Sparse word store
    logic [15:0] store [int];
    logic        busy;
    int          count;

    function automatic logic [15:0] peek(input logic [21:0] a);
        if (store.exists(int'(a))) begin
            return store[int'(a)];
        end
        return a[15:0] ^ 16'hA5A5;
    endfunction

    // Byte enables are active low
    function automatic logic [15:0] lane_write(input logic [15:0] old, input logic [15:0] d,
                                               input logic [1:0] en_n);
        return {en_n[1] ? old[15:8] : d[15:8], en_n[0] ? old[7:0] : d[7:0]};
    endfunction

    always @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            busy      <= 1'b0;
            count     <= 0;
            data_read <= '0;
        end else if (busy) begin
            if (count > 1) begin
                count <= count - 1;
            end else begin
                busy      <= 1'b0;
                sdram_ack <= 1'b1;
                if (prog_we) begin
                    store[int'(prog_addr)] = lane_write(peek(prog_addr), {prog_data, prog_data},
                                                        prog_mask);
                end else if (!sdram_rnw) begin
                    store[int'(sdram_addr)] = lane_write(peek(sdram_addr), data_write,
                                                         sdram_wrmask);
                end else begin
                    data_read <= {peek(sdram_addr + 22'd1), peek(sdram_addr)};
                end
            end
        end else if ((sdram_req || prog_we) && !sdram_ack) begin
            busy  <= 1'b1;
            count <= int'(latency);
        end else if (!sdram_req && !prog_we) begin
            // Four-phase close once the requester lets go
            sdram_ack <= 1'b0;
        end
    end

endmodule

// File: hdl/cps_mem_pkg.sv
// Fixed three-slot SDRAM map; state labels carry ARB_ and LD_ prefixes so both FSM enums share the package
package cps_mem_pkg;

    // SDRAM word address width
    localparam int SDRAM_AW = 22;

    // Number of client slots on the arbiter
    localparam int SLOT_COUNT = 3;

    // Region bases, in 16-bit SDRAM words
    localparam logic [SDRAM_AW-1:0] ROM_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET = 22'h3A_8000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET = 22'h0A_8000;

    // Client slots, lower value wins arbitration
    typedef enum logic [1:0] {
        SLOT_ROM = 2'd0,
        SLOT_RAM = 2'd1,
        SLOT_GFX = 2'd2
    } slot_e;

    // Request FSM shared by slot requesters and the arbiter
    typedef enum logic [1:0] {
        ARB_IDLE      = 2'd0,
        ARB_REQ       = 2'd1,
        ARB_WAIT_DROP = 2'd2
    } arb_state_e;

    // Download write FSM
    typedef enum logic [1:0] {
        LD_IDLE      = 2'd0,
        LD_WRITE     = 2'd1,
        LD_WAIT_DROP = 2'd2
    } load_state_e;

endpackage

// File: hdl/cps_mem_top.sv
// Loader and slot ports are separate; the outer framework muxes prog_* and sdram_* onto one SDRAM
`timescale 1ns/10ps

module cps_mem_top import cps_mem_pkg::*; (
    input  logic                VB,
    input  logic                rst_n,
    input  logic                downloading,
    // Download input
    input  logic [22:0]         ioctl_addr,
    input  logic [ 7:0]         ioctl_data,
    input  logic                ioctl_wr,
    // Program write port
    output logic [21:0]         prog_addr,
    output logic [ 7:0]         prog_data,
    output logic [ 1:0]         prog_mask,
    output logic                prog_we,
    // CPU ROM client
    input  logic                rom_cs,
    input  logic [19:0]         rom_addr,
    output logic [15:0]         rom_data,
    output logic                rom_ok,
    // Work RAM client
    input  logic                ram_cs,
    input  logic [16:0]         ram_addr,
    input  logic                ram_wr,
    input  logic [15:0]         ram_din,
    input  logic [ 1:0]         ram_mask,
    output logic [15:0]         ram_data,
    output logic                ram_ok,
    // Graphics ROM client
    input  logic                gfx_cs,
    input  logic [20:0]         gfx_addr,
    output logic [31:0]         gfx_data,
    output logic                gfx_ok,
    // SDRAM request port
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_rnw,
    output logic [15:0]         data_write,
    output logic [ 1:0]         sdram_wrmask,
    input  logic                sdram_ack,
    input  logic [31:0]         data_read
);

    logic [31:0]         rom_dout;
    logic [31:0]         ram_dout;
    logic                rom_freq, ram_freq, gfx_freq;
    logic [SDRAM_AW-1:0] rom_faddr, ram_faddr, gfx_faddr;
    logic                rom_fwr, ram_fwr, gfx_fwr;
    logic [15:0]         rom_fdin, ram_fdin, gfx_fdin;
    logic [ 1:0]         rom_fmask, ram_fmask, gfx_fmask;
    logic                rom_fack, ram_fack, gfx_fack;
    logic [31:0]         rom_fdata, ram_fdata, gfx_fdata;

    // 16-bit clients take the word at the address
    assign rom_data = rom_dout[15:0];
    assign ram_data = ram_dout[15:0];

    cps_rom_loader u_loader (
        .VB(VB), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .sdram_ack(sdram_ack),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_we(prog_we)
    );

    cps_slot_req u_rom (
        .VB(VB), .rst_n(rst_n), .cs(rom_cs), .addr({1'b0, rom_addr}),
        .wr(1'b0), .din(16'd0), .mask(2'b00), .offset(ROM_OFFSET),
        .ok(rom_ok), .dout(rom_dout),
        .fetch_req(rom_freq), .fetch_addr(rom_faddr), .fetch_wr(rom_fwr),
        .fetch_din(rom_fdin), .fetch_mask(rom_fmask),
        .fetch_ack(rom_fack), .fetch_data(rom_fdata)
    );

    cps_slot_req u_ram (
        .VB(VB), .rst_n(rst_n), .cs(ram_cs), .addr({4'd0, ram_addr}),
        .wr(ram_wr), .din(ram_din), .mask(ram_mask), .offset(RAM_OFFSET),
        .ok(ram_ok), .dout(ram_dout),
        .fetch_req(ram_freq), .fetch_addr(ram_faddr), .fetch_wr(ram_fwr),
        .fetch_din(ram_fdin), .fetch_mask(ram_fmask),
        .fetch_ack(ram_fack), .fetch_data(ram_fdata)
    );

    // Graphics reads return two consecutive words
    cps_slot_req u_gfx (
        .VB(VB), .rst_n(rst_n), .cs(gfx_cs), .addr(gfx_addr),
        .wr(1'b0), .din(16'd0), .mask(2'b00), .offset(GFX_OFFSET),
        .ok(gfx_ok), .dout(gfx_data),
        .fetch_req(gfx_freq), .fetch_addr(gfx_faddr), .fetch_wr(gfx_fwr),
        .fetch_din(gfx_fdin), .fetch_mask(gfx_fmask),
        .fetch_ack(gfx_fack), .fetch_data(gfx_fdata)
    );

    cps_slot_arbiter u_arb (
        .VB(VB), .rst_n(rst_n), .downloading(downloading),
        .rom_fetch_req(rom_freq), .rom_fetch_addr(rom_faddr), .rom_fetch_wr(rom_fwr),
        .rom_fetch_din(rom_fdin), .rom_fetch_mask(rom_fmask),
        .rom_fetch_ack(rom_fack), .rom_fetch_data(rom_fdata),
        .ram_fetch_req(ram_freq), .ram_fetch_addr(ram_faddr), .ram_fetch_wr(ram_fwr),
        .ram_fetch_din(ram_fdin), .ram_fetch_mask(ram_fmask),
        .ram_fetch_ack(ram_fack), .ram_fetch_data(ram_fdata),
        .gfx_fetch_req(gfx_freq), .gfx_fetch_addr(gfx_faddr), .gfx_fetch_wr(gfx_fwr),
        .gfx_fetch_din(gfx_fdin), .gfx_fetch_mask(gfx_fmask),
        .gfx_fetch_ack(gfx_fack), .gfx_fetch_data(gfx_fdata),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_rnw(sdram_rnw),
        .data_write(data_write), .sdram_wrmask(sdram_wrmask),
        .sdram_ack(sdram_ack), .data_read(data_read)
    );

endmodule

// File: hdl/cps_rom_loader.sv
// One byte in flight at a time; ioctl_wr is ignored until prog_we and sdram_ack are low, keep downloading high meanwhile
`timescale 1ns/10ps

module cps_rom_loader import cps_mem_pkg::*; (
    input  logic        VB,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [22:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic        prog_we
);

    load_state_e state;
    logic        take_byte;

    // A new byte is only taken while idle
    assign take_byte = (state == LD_IDLE) && downloading && ioctl_wr;

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state   <= LD_IDLE;
            prog_we <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (take_byte) begin
                        prog_we <= 1'b1;
                        state   <= LD_WRITE;
                    end
                end
                LD_WRITE: begin
                    // Hold the write until the SDRAM side acknowledges
                    if (sdram_ack) begin
                        prog_we <= 1'b0;
                        state   <= LD_WAIT_DROP;
                    end
                end
                LD_WAIT_DROP: begin
                    if (!sdram_ack) begin
                        state <= LD_IDLE;
                    end
                end
                default: begin
                    prog_we <= 1'b0;
                    state   <= LD_IDLE;
                end
            endcase
        end
    end

    // Byte latch, word address and active-low byte lane
    always_ff @(posedge VB) begin
        if (take_byte) begin
            prog_addr <= ioctl_addr[22:1];
            prog_data <= ioctl_data;
            // Odd byte goes to the low lane
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
        end
    end

    // Program writes stay inside a download
    a_we_in_download: assert property (
        @(posedge VB) disable iff (!rst_n)
        prog_we |-> downloading
    );

endmodule

// File: hdl/cps_slot_arbiter.sv
// Fixed priority ROM over RAM over graphics; no grants during download and one SDRAM access at a time
`timescale 1ns/10ps

module cps_slot_arbiter import cps_mem_pkg::*; (
    input  logic                VB,
    input  logic                rst_n,
    input  logic                downloading,
    // CPU ROM slot
    input  logic                rom_fetch_req,
    input  logic [SDRAM_AW-1:0] rom_fetch_addr,
    input  logic                rom_fetch_wr,
    input  logic [15:0]         rom_fetch_din,
    input  logic [ 1:0]         rom_fetch_mask,
    output logic                rom_fetch_ack,
    output logic [31:0]         rom_fetch_data,
    // Work RAM slot
    input  logic                ram_fetch_req,
    input  logic [SDRAM_AW-1:0] ram_fetch_addr,
    input  logic                ram_fetch_wr,
    input  logic [15:0]         ram_fetch_din,
    input  logic [ 1:0]         ram_fetch_mask,
    output logic                ram_fetch_ack,
    output logic [31:0]         ram_fetch_data,
    // Graphics ROM slot
    input  logic                gfx_fetch_req,
    input  logic [SDRAM_AW-1:0] gfx_fetch_addr,
    input  logic                gfx_fetch_wr,
    input  logic [15:0]         gfx_fetch_din,
    input  logic [ 1:0]         gfx_fetch_mask,
    output logic                gfx_fetch_ack,
    output logic [31:0]         gfx_fetch_data,
    // SDRAM request port
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_rnw,
    output logic [15:0]         data_write,
    output logic [ 1:0]         sdram_wrmask,
    input  logic                sdram_ack,
    input  logic [31:0]         data_read
);

    arb_state_e            state;
    slot_e                 grant;
    slot_e                 pick;
    logic [SLOT_COUNT-1:0] req_vec;
    logic [SLOT_COUNT-1:0] ack_vec;
    logic [31:0]           data_q;
    logic                  go;

    always_comb begin
        req_vec[SLOT_ROM] = rom_fetch_req;
        req_vec[SLOT_RAM] = ram_fetch_req;
        req_vec[SLOT_GFX] = gfx_fetch_req;
    end

    // Lowest pending slot wins
    always_comb begin
        pick = SLOT_ROM;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                pick = slot_e'(i);
            end
        end
    end

    assign go = (state == ARB_IDLE) && !downloading && (|req_vec);

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            grant     <= SLOT_ROM;
            sdram_req <= 1'b0;
            ack_vec   <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (go) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (sdram_ack) begin
                        sdram_req      <= 1'b0;
                        ack_vec[grant] <= 1'b1;
                        state          <= ARB_WAIT_DROP;
                    end
                end
                ARB_WAIT_DROP: begin
                    // Both the slot and the memory must close their handshakes
                    if (!req_vec[grant] && !sdram_ack) begin
                        ack_vec <= '0;
                        state   <= ARB_IDLE;
                    end
                end
                default: begin
                    sdram_req <= 1'b0;
                    ack_vec   <= '0;
                    state     <= ARB_IDLE;
                end
            endcase
        end
    end

    // Copy of the granted request onto the SDRAM port
    always_ff @(posedge VB) begin
        if (go) begin
            case (pick)
                SLOT_RAM: begin
                    sdram_addr   <= ram_fetch_addr;
                    sdram_rnw    <= !ram_fetch_wr;
                    data_write   <= ram_fetch_din;
                    sdram_wrmask <= ram_fetch_mask;
                end
                SLOT_GFX: begin
                    sdram_addr   <= gfx_fetch_addr;
                    sdram_rnw    <= !gfx_fetch_wr;
                    data_write   <= gfx_fetch_din;
                    sdram_wrmask <= gfx_fetch_mask;
                end
                default: begin
                    sdram_addr   <= rom_fetch_addr;
                    sdram_rnw    <= !rom_fetch_wr;
                    data_write   <= rom_fetch_din;
                    sdram_wrmask <= rom_fetch_mask;
                end
            endcase
        end
        if (state == ARB_REQ && sdram_ack) begin
            data_q <= data_read;
        end
    end

    // Data is shared, the ack picks the slot
    assign rom_fetch_data = data_q;
    assign ram_fetch_data = data_q;
    assign gfx_fetch_data = data_q;

    assign rom_fetch_ack = ack_vec[SLOT_ROM];
    assign ram_fetch_ack = ack_vec[SLOT_RAM];
    assign gfx_fetch_ack = ack_vec[SLOT_GFX];

    a_one_ack: assert property (
        @(posedge VB) disable iff (!rst_n)
        $onehot0({rom_fetch_ack, ram_fetch_ack, gfx_fetch_ack})
    );

    // Loader owns the SDRAM while downloading
    a_quiet_in_download: assert property (
        @(posedge VB) disable iff (!rst_n)
        downloading |-> !sdram_req
    );

endmodule

// File: hdl/cps_slot_req.sv
// Single-entry read cache per slot; addr is zero-extended and added to offset, writes drop the entry
`timescale 1ns/10ps

module cps_slot_req import cps_mem_pkg::*; (
    input  logic                VB,
    input  logic                rst_n,
    input  logic                cs,
    input  logic [20:0]         addr,
    input  logic                wr,
    input  logic [15:0]         din,
    input  logic [ 1:0]         mask,
    input  logic [SDRAM_AW-1:0] offset,
    output logic                ok,
    output logic [31:0]         dout,
    output logic                fetch_req,
    output logic [SDRAM_AW-1:0] fetch_addr,
    output logic                fetch_wr,
    output logic [15:0]         fetch_din,
    output logic [ 1:0]         fetch_mask,
    input  logic                fetch_ack,
    input  logic [31:0]         fetch_data
);

    arb_state_e  state;
    logic [20:0] cache_addr;
    logic [31:0] cache_data;
    logic        cache_valid;
    logic        hit;
    logic        start;

    assign hit   = !wr && cache_valid && (addr == cache_addr);
    assign start = (state == ARB_IDLE) && cs;

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ARB_IDLE;
            ok          <= 1'b0;
            fetch_req   <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (cs && hit) begin
                        // Served from the cache, no SDRAM access
                        ok    <= 1'b1;
                        state <= ARB_WAIT_DROP;
                    end else if (cs) begin
                        fetch_req   <= 1'b1;
                        cache_valid <= 1'b0;
                        state       <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (fetch_ack) begin
                        fetch_req   <= 1'b0;
                        ok          <= 1'b1;
                        cache_valid <= !fetch_wr;
                        state       <= ARB_WAIT_DROP;
                    end
                end
                ARB_WAIT_DROP: begin
                    // Client releases cs, fetch side must be idle too
                    if (!cs && !fetch_ack) begin
                        ok    <= 1'b0;
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    ok        <= 1'b0;
                    fetch_req <= 1'b0;
                    state     <= ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge VB) begin
        if (start && !hit) begin
            fetch_addr <= offset + {1'b0, addr};
            fetch_wr   <= wr;
            fetch_din  <= din;
            fetch_mask <= mask;
            cache_addr <= addr;
        end
        if (start && hit) begin
            dout <= cache_data;
        end
        if (state == ARB_REQ && fetch_ack) begin
            dout       <= fetch_data;
            cache_data <= fetch_data;
        end
    end

    // ok must answer a select seen on the previous edge
    a_ok_needs_cs: assert property (
        @(posedge VB) disable iff (!rst_n)
        $rose(ok) |-> $past(cs)
    );

endmodule
